/* rtl/ieuPkg.sv */
// Integer execute unit definitions
`default_nettype none

package ieuPkg;

	// Bus and datapath sizes
	localparam int addrW    = 6;
	localparam int dataW    = 32;
	localparam int regCnt   = 8;
	localparam int regAddrW = $clog2(regCnt);
	localparam int opW      = 6;

	// Register map, byte addresses
	// r0..r7 occupy one word each starting at regBase
	localparam logic [addrW-1:0] regBase = 6'h00;
	localparam logic [addrW-1:0] cmdAddr = 6'h20;
	localparam logic [addrW-1:0] iccAddr = 6'h24;

	// Base opcodes, S bit clear
	localparam logic [opW-1:0] opAdd  = 6'h00;
	localparam logic [opW-1:0] opAnd  = 6'h01;
	localparam logic [opW-1:0] opOr   = 6'h02;
	localparam logic [opW-1:0] opXor  = 6'h03;
	localparam logic [opW-1:0] opSub  = 6'h04;
	localparam logic [opW-1:0] opAndn = 6'h05;
	localparam logic [opW-1:0] opOrn  = 6'h06;
	localparam logic [opW-1:0] opXnor = 6'h07;
	localparam logic [opW-1:0] opAddx = 6'h08;
	localparam logic [opW-1:0] opSubx = 6'h0C;
	// Shifts have no flag-setting form
	localparam logic [opW-1:0] opSll  = 6'h25;
	localparam logic [opW-1:0] opSrl  = 6'h26;
	localparam logic [opW-1:0] opSra  = 6'h27;

	// Flag-set bit inside the opcode
	localparam int sBit = 4;

	// AXI response codes
	localparam logic [1:0] respOkay   = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Integer condition codes, bits 3:0 of the ICC word
	typedef struct packed {
		logic n;
		logic z;
		logic v;
		logic c;
	} iccT;

	// Command word layout
	typedef struct packed {
		logic [12:0]         rsvd31;
		logic [regAddrW-1:0] rd;
		logic                rsvd15;
		logic [regAddrW-1:0] rs2;
		logic                rsvd11;
		logic [regAddrW-1:0] rs1;
		logic [1:0]          rsvd7;
		logic [opW-1:0]      op;
	} cmdT;

	// Operands into the ALU
	typedef struct packed {
		logic [opW-1:0]   op;
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic             cin;
	} aluReqT;

	// Result and flags out of the ALU
	typedef struct packed {
		logic [dataW-1:0] res;
		iccT              icc;
		logic             iccWe;
		logic             legal;
	} aluRspT;

endpackage

`default_nettype wire

/* rtl/alu.sv */
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  ieuPkg::aluReqT req,
	output ieuPkg::aluRspT rsp
);
	import ieuPkg::*;

	// Which flag rule the selected operation follows
	typedef enum logic [1:0] {
		fkNone,
		fkAdd,
		fkSub,
		fkLogic
	} flagKindT;

	logic [opW-1:0] baseOp;
	logic           sFlag;
	logic           cinEff;
	logic [dataW:0] addWide;
	logic [dataW:0] subWide;
	logic [4:0]     shAmt;
	flagKindT       flagKind;

	// Flags for add-type results
	function automatic iccT addIcc(input logic [dataW-1:0] a, input logic [dataW-1:0] b,
		input logic [dataW:0] wide);
		iccT f;
		f.n = wide[dataW-1];
		f.z = (wide[dataW-1:0] == '0);
		// Same-sign operands giving the other sign
		f.v = (a[dataW-1] == b[dataW-1]) && (wide[dataW-1] != a[dataW-1]);
		f.c = wide[dataW];
		return f;
	endfunction

	// Flags for subtract-type results
	function automatic iccT subIcc(input logic [dataW-1:0] a, input logic [dataW-1:0] b,
		input logic [dataW:0] wide);
		iccT f;
		f.n = wide[dataW-1];
		f.z = (wide[dataW-1:0] == '0);
		// Differing signs and result sign not that of a
		f.v = (a[dataW-1] != b[dataW-1]) && (wide[dataW-1] != a[dataW-1]);
		// Top bit of the wrapped difference is the borrow
		f.c = wide[dataW];
		return f;
	endfunction

	// Logic results clear V and C
	function automatic iccT logicIcc(input logic [dataW-1:0] r);
		iccT f;
		f.n = r[dataW-1];
		f.z = (r == '0);
		f.v = 1'b0;
		f.c = 1'b0;
		return f;
	endfunction

	// Split the opcode into base operation and S bit
	always_comb
	begin
		sFlag = req.op[sBit];
		baseOp = req.op;
		baseOp[sBit] = 1'b0;
		// Only the low five bits of b count for shifts
		shAmt = req.b[4:0];
		// Carry in only for ADDX and SUBX
		cinEff = ((baseOp == opAddx) || (baseOp == opSubx)) ? req.cin : 1'b0;
		addWide = {1'b0, req.a} + {1'b0, req.b} + {{dataW{1'b0}}, cinEff};
		subWide = {1'b0, req.a} - {1'b0, req.b} - {{dataW{1'b0}}, cinEff};
	end

	always_comb
	begin
		rsp = '0;
		flagKind = fkNone;
		case (baseOp)
			opAdd, opAddx:
			begin
				rsp.res = addWide[dataW-1:0];
				flagKind = fkAdd;
			end
			opSub, opSubx:
			begin
				rsp.res = subWide[dataW-1:0];
				flagKind = fkSub;
			end
			opAnd:
			begin
				rsp.res = req.a & req.b;
				flagKind = fkLogic;
			end
			opOr:
			begin
				rsp.res = req.a | req.b;
				flagKind = fkLogic;
			end
			opXor:
			begin
				rsp.res = req.a ^ req.b;
				flagKind = fkLogic;
			end
			// Negated forms invert the second operand
			opAndn:
			begin
				rsp.res = req.a & ~req.b;
				flagKind = fkLogic;
			end
			opOrn:
			begin
				rsp.res = req.a | ~req.b;
				flagKind = fkLogic;
			end
			opXnor:
			begin
				rsp.res = req.a ^ ~req.b;
				flagKind = fkLogic;
			end
			// Shifts exist only with the S bit clear
			opSll:
			begin
				rsp.res = req.a << shAmt;
				rsp.legal = ~sFlag;
			end
			opSrl:
			begin
				rsp.res = req.a >> shAmt;
				rsp.legal = ~sFlag;
			end
			opSra:
			begin
				rsp.res = $signed(req.a) >>> shAmt;
				rsp.legal = ~sFlag;
			end
			default:
			begin
				rsp.res = '0;
			end
		endcase

		case (flagKind)
			fkAdd:   rsp.icc = addIcc(req.a, req.b, addWide);
			fkSub:   rsp.icc = subIcc(req.a, req.b, subWide);
			fkLogic: rsp.icc = logicIcc(rsp.res);
			default: rsp.icc = '0;
		endcase

		// Arithmetic and logic ops are always legal, flags follow S
		if (flagKind != fkNone)
		begin
			rsp.legal = 1'b1;
			rsp.iccWe = sFlag;
		end
	end

endmodule

`default_nettype wire

/* rtl/condCodes.sv */
// Integer condition codes
`timescale 1ns/1ps
`default_nettype none

module condCodes (
	input  logic           clk,
	input  logic           arstN,
	// Command write-back strobe and ALU outcome
	input  logic           aluUpd,
	input  ieuPkg::aluRspT aluRsp,
	// Direct bus write
	input  logic           iccWr,
	input  ieuPkg::iccT    wrIcc,
	output ieuPkg::iccT    icc
);

	// N Z V C held here, C feeds the ALU carry in
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			icc <= '0;
		end
		else if (iccWr)
		begin
			// Bus value taken as written
			icc <= wrIcc;
		end
		else if (aluUpd && aluRsp.iccWe)
		begin
			icc <= aluRsp.icc;
		end
	end

	// The bus side issues at most one write per cycle
	assert property (@(posedge clk) disable iff (!arstN) !(aluUpd && iccWr))
	else $error("condCodes: ALU update and bus write in the same cycle");

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                         clk,
	input  logic                         arstN,
	// Operand ports for rs1 and rs2
	input  logic [ieuPkg::regAddrW-1:0]  rdAddr1,
	input  logic [ieuPkg::regAddrW-1:0]  rdAddr2,
	// Bus read port
	input  logic [ieuPkg::regAddrW-1:0]  rdAddr3,
	output logic [ieuPkg::dataW-1:0]     rdData1,
	output logic [ieuPkg::dataW-1:0]     rdData2,
	output logic [ieuPkg::dataW-1:0]     rdData3,
	// Single write port
	input  logic                         we,
	input  logic [ieuPkg::regAddrW-1:0]  wrAddr,
	input  logic [ieuPkg::dataW-1:0]     wrData
);
	import ieuPkg::*;

	logic [dataW-1:0] regs [regCnt];

	// r0 is hardwired to zero like g0
	function automatic logic [dataW-1:0] readReg(input logic [regAddrW-1:0] idx);
		logic [dataW-1:0] val;
		val = (idx == '0) ? '0 : regs[idx];
		return val;
	endfunction

	// Writes to r0 are dropped
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < regCnt; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && (wrAddr != '0))
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads see the value before this edge's write
	always_comb
	begin
		rdData1 = readReg(rdAddr1);
		rdData2 = readReg(rdAddr2);
		rdData3 = readReg(rdAddr3);
	end

endmodule

`default_nettype wire

/* rtl/axilRegIf.sv */
// AXI4-Lite register interface
`timescale 1ns/1ps
`default_nettype none

module axilRegIf (
	input  logic                          clk,
	input  logic                          arstN,
	// Write address and data channels
	input  logic [ieuPkg::addrW-1:0]      awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [ieuPkg::dataW-1:0]      wdata,
	input  logic [ieuPkg::dataW/8-1:0]    wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	// Write response
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	// Read channels
	input  logic [ieuPkg::addrW-1:0]      araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [ieuPkg::dataW-1:0]      rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,
	// ALU
	output ieuPkg::aluReqT                aluReq,
	input  ieuPkg::aluRspT                aluRsp,
	// Condition codes
	input  ieuPkg::iccT                   icc,
	output logic                          aluUpd,
	output logic                          iccWr,
	output ieuPkg::iccT                   wrIcc,
	// Register file
	output logic [ieuPkg::regAddrW-1:0]   rdAddr1,
	output logic [ieuPkg::regAddrW-1:0]   rdAddr2,
	output logic [ieuPkg::regAddrW-1:0]   rdAddr3,
	input  logic [ieuPkg::dataW-1:0]      rdData1,
	input  logic [ieuPkg::dataW-1:0]      rdData2,
	input  logic [ieuPkg::dataW-1:0]      rdData3,
	output logic                          we,
	output logic [ieuPkg::regAddrW-1:0]   wrAddr,
	output logic [ieuPkg::dataW-1:0]      wrData
);
	import ieuPkg::*;

	logic [addrW-1:0] wrWord;
	logic [addrW-1:0] rdWord;
	logic [addrW-1:0] wrOff;
	logic [addrW-1:0] rdOff;
	logic             wrRegHit;
	logic             wrCmdHit;
	logic             wrIccHit;
	logic             rdRegHit;
	logic             rdIccHit;
	logic             wrAccept;
	logic             rdAccept;
	logic [1:0]       wrResp;
	logic [1:0]       rdResp;
	logic [dataW-1:0] rdNext;
	cmdT              cmd;

	// A pending response blocks its own channel
	assign awready = ~bvalid;
	assign wready = ~bvalid;
	assign arready = ~rvalid;
	assign wrAccept = awvalid & wvalid & ~bvalid;
	assign rdAccept = arvalid & ~rvalid;

	// Word decode, byte offset bits ignored
	assign wrWord = {awaddr[addrW-1:2], 2'b00};
	assign rdWord = {araddr[addrW-1:2], 2'b00};
	assign wrOff = wrWord - regBase;
	assign rdOff = rdWord - regBase;
	assign wrRegHit = (wrWord >= regBase) && (wrOff < addrW'(regCnt * 4));
	assign rdRegHit = (rdWord >= regBase) && (rdOff < addrW'(regCnt * 4));
	assign wrCmdHit = (wrWord == cmdAddr);
	assign wrIccHit = (wrWord == iccAddr);
	assign rdIccHit = (rdWord == iccAddr);

	// Command fields straight from write data, executes in the accept cycle
	assign cmd = cmdT'(wdata);
	assign rdAddr1 = cmd.rs1;
	assign rdAddr2 = cmd.rs2;
	assign aluReq = '{op: cmd.op, a: rdData1, b: rdData2, cin: icc.c};

	// Direct ICC write uses the low nibble
	assign wrIcc = iccT'(wdata[3:0]);

	// Write routing and response code
	always_comb
	begin
		we = 1'b0;
		wrAddr = wrOff[2 +: regAddrW];
		wrData = wdata;
		aluUpd = 1'b0;
		iccWr = 1'b0;
		wrResp = respSlvErr;
		if (wrRegHit)
		begin
			// r0 writes answer OKAY, the file drops them
			wrResp = respOkay;
			we = wrAccept;
		end
		else if (wrCmdHit)
		begin
			// Illegal opcode leaves SLVERR and no state change
			if (aluRsp.legal)
			begin
				wrResp = respOkay;
				we = wrAccept;
				wrAddr = cmd.rd;
				wrData = aluRsp.res;
				aluUpd = wrAccept;
			end
		end
		else if (wrIccHit)
		begin
			wrResp = respOkay;
			iccWr = wrAccept;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			bvalid <= 1'b0;
			bresp <= respOkay;
		end
		else if (wrAccept)
		begin
			bvalid <= 1'b1;
			bresp <= wrResp;
		end
		else if (bready)
		begin
			bvalid <= 1'b0;
		end
	end

	// Read path, command word reads back as unmapped
	assign rdAddr3 = rdOff[2 +: regAddrW];

	always_comb
	begin
		rdNext = '0;
		rdResp = respSlvErr;
		if (rdRegHit)
		begin
			rdNext = rdData3;
			rdResp = respOkay;
		end
		else if (rdIccHit)
		begin
			rdNext = dataW'(icc);
			rdResp = respOkay;
		end
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rvalid <= 1'b0;
			rresp <= respOkay;
		end
		else if (rdAccept)
		begin
			rvalid <= 1'b1;
			rresp <= rdResp;
		end
		else if (rready)
		begin
			rvalid <= 1'b0;
		end
	end

	// Read data captured at address accept
	always_ff @(posedge clk)
	begin
		if (rdAccept)
			rdata <= rdNext;
	end

	// Write response holds with a stable code until taken
	assert property (@(posedge clk) disable iff (!arstN)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else $error("axilRegIf: write response dropped before bready");

	// Partial strobes still write the full word
	assert property (@(posedge clk) disable iff (!arstN) wrAccept |-> (wstrb == '1))
	else $warning("axilRegIf: partial wstrb %h treated as full-word write", wstrb);

endmodule

`default_nettype wire

/* rtl/ieuTop.sv */
// Integer execute unit top
`timescale 1ns/1ps
`default_nettype none

module ieuTop (
	input  logic                        clk,
	input  logic                        arstN,
	// AXI4-Lite slave
	input  logic [ieuPkg::addrW-1:0]    awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [ieuPkg::dataW-1:0]    wdata,
	input  logic [ieuPkg::dataW/8-1:0]  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [ieuPkg::addrW-1:0]    araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [ieuPkg::dataW-1:0]    rdata,
	output logic [1:0]                  rresp,
	output logic                        rvalid,
	input  logic                        rready
);
	import ieuPkg::*;

	// Datapath between bus front end, ALU, flags and registers
	aluReqT              aluReq;
	aluRspT              aluRsp;
	iccT                 icc;
	iccT                 wrIcc;
	logic                aluUpd;
	logic                iccWr;
	logic [regAddrW-1:0] rdAddr1;
	logic [regAddrW-1:0] rdAddr2;
	logic [regAddrW-1:0] rdAddr3;
	logic [dataW-1:0]    rdData1;
	logic [dataW-1:0]    rdData2;
	logic [dataW-1:0]    rdData3;
	logic                we;
	logic [regAddrW-1:0] wrAddr;
	logic [dataW-1:0]    wrData;

	axilRegIf uRegIf (.*);

	alu uAlu (
		.req (aluReq),
		.rsp (aluRsp)
	);

	condCodes uCondCodes (.*);

	regFile uRegFile (.*);

endmodule

`default_nettype wire

/* dv/clkRstGen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module clkRstGen (
	output logic clk,
	output logic arstN
);

	localparam time halfPeriod = 5ns;
	localparam int  rstCycles  = 4;

	// 10 ns free-running clock
	initial
	begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Reset held low for four rising edges, released just after the last
	initial
	begin
		arstN = 1'b0;
		repeat (rstCycles) @(posedge clk);
		#1;
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/ieuTopTb.sv */
// Execute unit testbench
`timescale 1ns/1ps
`default_nettype none

module ieuTopTb;
	import ieuPkg::*;

	// Entry kinds, reads and writes of each target
	typedef enum logic [2:0] {
		kWrReg,
		kWrIcc,
		kCmd,
		kRdReg,
		kRdIcc
	} kindT;

	typedef struct packed {
		kindT        kind;
		logic [5:0]  addr;
		logic [31:0] data;
		logic [1:0]  resp;
		logic [31:0] expData;
	} entryT;

	// Flag-set form of an opcode
	localparam logic [5:0] sOn = 6'h10;
	localparam int wdCyclesPerEntry = 200;
	localparam int wdExtraCycles = 20;

	logic        clk;
	logic        arstN;
	logic [5:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [5:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	entryT       tbl[$];
	int          errCnt;
	logic        tableDone;

	clkRstGen uClkRst (
		.clk   (clk),
		.arstN (arstN)
	);

	ieuTop DUT (.*);

	// Command word: rd 18:16, rs2 14:12, rs1 10:8, op 5:0
	function automatic logic [31:0] cmdWord(input logic [5:0] op, input logic [2:0] rd,
		input logic [2:0] rs1, input logic [2:0] rs2);
		return {13'b0, rd, 1'b0, rs2, 1'b0, rs1, 2'b00, op};
	endfunction

	function automatic entryT mkEntry(input kindT kind, input logic [5:0] addr,
		input logic [31:0] data, input logic [1:0] resp, input logic [31:0] expData);
		entryT e;
		e.kind = kind;
		e.addr = addr;
		e.data = data;
		e.resp = resp;
		e.expData = expData;
		return e;
	endfunction

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errCnt++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	// Holds bready or rready off for 0 to 3 cycles
	task automatic randomStall();
		int unsigned delay;
		delay = $urandom % 4;
		repeat (delay)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// All bus tasks start and end 1 ns after a rising edge
	task automatic busWrite(input logic [5:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		logic accepted;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		accepted = 1'b0;
		// Readies are stable between edges, so sample them here
		while (!accepted)
		begin
			accepted = awready && wready;
			@(posedge clk);
			#1;
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
		begin
			@(posedge clk);
			#1;
		end
		randomStall();
		// Response must survive the stall
		checkVal("bvalid", 32'(bvalid), 32'h1);
		resp = bresp;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic busRead(input logic [5:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		logic accepted;
		araddr = addr;
		arvalid = 1'b1;
		accepted = 1'b0;
		while (!accepted)
		begin
			accepted = arready;
			@(posedge clk);
			#1;
		end
		arvalid = 1'b0;
		while (!rvalid)
		begin
			@(posedge clk);
			#1;
		end
		randomStall();
		checkVal("rvalid", 32'(rvalid), 32'h1);
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// Stimulus table, expected values worked out by hand
	task automatic buildTable();
		// Reset state of every register and the flags
		for (int i = 0; i < 8; i++)
			tbl.push_back(mkEntry(kRdReg, 6'(i * 4), '0, respOkay, '0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, '0));
		// Operands, r0 write dropped
		tbl.push_back(mkEntry(kWrReg, 6'h00, 32'hDEADBEEF, respOkay, '0));
		tbl.push_back(mkEntry(kWrReg, 6'h04, 32'h7FFFFFFF, respOkay, '0));
		tbl.push_back(mkEntry(kWrReg, 6'h08, 32'h00000001, respOkay, '0));
		tbl.push_back(mkEntry(kWrReg, 6'h0C, 32'hFFFFFFFF, respOkay, '0));
		tbl.push_back(mkEntry(kWrReg, 6'h10, 32'h0F0F1234, respOkay, '0));
		tbl.push_back(mkEntry(kWrReg, 6'h14, 32'hFF00FF00, respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h00, '0, respOkay, 32'h0));
		tbl.push_back(mkEntry(kRdReg, 6'h04, '0, respOkay, 32'h7FFFFFFF));
		tbl.push_back(mkEntry(kRdReg, 6'h0C, '0, respOkay, 32'hFFFFFFFF));
		// 0x7FFFFFFF + 1 gives N and V
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAdd | sOn, 6, 1, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h80000000));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'hA));
		// 0xFFFFFFFF + 1 gives Z and C
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAdd | sOn, 6, 3, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h5));
		// 0 - 1 gives N and borrow
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSub | sOn, 6, 0, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hFFFFFFFF));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h9));
		// Plain ADD and SUB keep the flags, their own flags would be 0xA and 0x0
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAdd, 7, 1, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h1C, '0, respOkay, 32'h80000000));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h9));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSub, 7, 1, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h1C, '0, respOkay, 32'h7FFFFFFE));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h9));
		// Logic ops, V and C preset so the clear shows
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h3, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAnd | sOn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0F001200));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h0));
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h3, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opOr | sOn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hFF0FFF34));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h8));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opXor | sOn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hF00FED34));
		// Zero result sets Z only
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h3, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAnd | sOn, 6, 4, 0), respOkay, '0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h4));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAndn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h000F0034));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opOrn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0FFF12FF));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h4));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opXnor | sOn, 6, 4, 5), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0FF012CB));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h0));
		// Carry in with C set, then clear
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h1, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAddx, 6, 2, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h3));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSubx, 6, 4, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0F0F1232));
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h0, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAddx, 6, 2, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h2));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSubx, 6, 4, 2), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0F0F1233));
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'h1, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opAddx | sOn, 6, 3, 0), respOkay, '0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'h5));
		// Shift amount 0x24 counts as 4, flags preset to 0xA
		tbl.push_back(mkEntry(kWrReg, 6'h1C, 32'h00000024, respOkay, '0));
		tbl.push_back(mkEntry(kWrIcc, iccAddr, 32'hA, respOkay, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSll, 6, 4, 7), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hF0F12340));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSrl, 6, 5, 7), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'h0FF00FF0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSra, 6, 5, 7), respOkay, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hFFF00FF0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'hA));
		// Unknown opcode and flag-set shift are rejected
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(6'h3F, 6, 4, 5), respSlvErr, '0));
		tbl.push_back(mkEntry(kCmd, cmdAddr, cmdWord(opSll | sOn, 6, 4, 7), respSlvErr, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h18, '0, respOkay, 32'hFFF00FF0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'hA));
		// Off-map addresses, 0x28 shares its low offset bits with r2
		tbl.push_back(mkEntry(kWrReg, 6'h28, 32'h12345678, respSlvErr, '0));
		tbl.push_back(mkEntry(kRdReg, 6'h08, '0, respOkay, 32'h00000001));
		tbl.push_back(mkEntry(kRdReg, 6'h2C, '0, respSlvErr, 32'h0));
		tbl.push_back(mkEntry(kRdReg, cmdAddr, '0, respSlvErr, 32'h0));
		tbl.push_back(mkEntry(kRdIcc, iccAddr, '0, respOkay, 32'hA));
	endtask

	// Watchdog sized from the table length
	initial
	begin
		wait (tableDone);
		repeat (tbl.size() * wdCyclesPerEntry + wdExtraCycles) @(posedge clk);
		$display("Timeout: the bus transactions did not complete in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial
	begin
		entryT       e;
		logic [31:0] rdVal;
		logic [1:0]  resp;
		void'($urandom(1951));
		errCnt = 0;
		tableDone = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		buildTable();
		tableDone = 1'b1;
		wait (arstN);
		@(posedge clk);
		#1;
		for (int i = 0; i < tbl.size(); i++)
		begin
			e = tbl[i];
			if (e.kind == kRdReg || e.kind == kRdIcc)
			begin
				busRead(e.addr, rdVal, resp);
				checkVal($sformatf("rresp[%0d]", i), 32'(resp), 32'(e.resp));
				checkVal($sformatf("rdata[%0d]", i), rdVal, e.expData);
			end
			else
			begin
				busWrite(e.addr, e.data, resp);
				checkVal($sformatf("bresp[%0d]", i), 32'(resp), 32'(e.resp));
			end
		end
		$display("Run complete: %0d entries, %0d errors", tbl.size(), errCnt);
		if (errCnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/ieuPkg.sv
rtl/alu.sv
rtl/condCodes.sv
rtl/regFile.sv
rtl/axilRegIf.sv
rtl/ieuTop.sv
dv/clkRstGen.sv
dv/ieuTopTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module ieuTopTb \
	--Mdir obj_dir -o simv > build.log 2>&1 \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed"
exit 0
